/* csr_pkg.sv */
package csr_pkg;

    // CSR address space
    localparam int CSR_ADDR_W = 14;

    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_ADDR_W-1:0] CSR_PRMD   = 14'h001;
    localparam logic [CSR_ADDR_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY = 14'h00c;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE0  = 14'h030;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE1  = 14'h031;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE2  = 14'h032;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE3  = 14'h033;
    localparam logic [CSR_ADDR_W-1:0] CSR_TID    = 14'h040;
    localparam logic [CSR_ADDR_W-1:0] CSR_TCFG   = 14'h041;
    localparam logic [CSR_ADDR_W-1:0] CSR_TVAL   = 14'h042;
    localparam logic [CSR_ADDR_W-1:0] CSR_TICLR  = 14'h044;

    // Exception codes as recorded in ESTAT.Ecode
    localparam int ECODE_W = 6;

    localparam logic [ECODE_W-1:0] ECODE_INT = 6'd0;  // Interrupt
    localparam logic [ECODE_W-1:0] ECODE_SYS = 6'd11; // Syscall
    localparam logic [ECODE_W-1:0] ECODE_BRK = 6'd12; // Breakpoint

    // Interrupt status field of ESTAT and enable field of ECFG
    // Bits 1:0 software, 9:2 hardware lines, 11 timer
    localparam int IS_W = 13;

    // Trap controller sequence, one state per cycle of the trap
    typedef enum logic [1:0] {
        TRAP_IDLE     = 2'd0,
        TRAP_COMMIT   = 2'd1,
        TRAP_REDIRECT = 2'd2
    } trap_state_t;

endpackage

/* csr_properties.sv */
`timescale 1ns/1ps

module csr_trap_props import csr_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input trap_state_t state_q,
    input logic        trap_commit,
    input logic        busy,
    input logic        redirect_valid
);

    int fails = 0;

    // The redirect cycle comes right after the commit cycle and only then
    assert property (@(posedge clk) disable iff (!rst_n) trap_commit |=> redirect_valid)
        else begin fails++; $error("redirect_valid missing after trap_commit"); end
    assert property (@(posedge clk) disable iff (!rst_n) redirect_valid |-> $past(trap_commit))
        else begin fails++; $error("redirect_valid without a preceding trap_commit"); end

    // Busy covers exactly the two legal trap states, so the unused encoding never shows up
    assert property (@(posedge clk) disable iff (!rst_n)
                     busy == (state_q inside {TRAP_COMMIT, TRAP_REDIRECT}))
        else begin fails++; $error("busy does not match the trap state"); end

    assert property (@(posedge clk) disable iff (!rst_n) redirect_valid |=> !redirect_valid)
        else begin fails++; $error("redirect_valid high for two cycles"); end

    assert property (@(posedge clk) !rst_n |-> !trap_commit)
        else begin fails++; $error("trap_commit high during reset"); end

endmodule

bind csr_trap_ctrl csr_trap_props i_trap_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .state_q        (state_q),
    .trap_commit    (trap_commit),
    .busy           (busy),
    .redirect_valid (redirect_valid)
);

/* csr_regfile.sv */
`timescale 1ns/1ps

module csr_regfile import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [CSR_ADDR_W-1:0] addr,
    input  logic                  we,
    input  logic [31:0]           wdata,
    input  logic [7:0]            hwi,
    input  logic                  timer_fire,
    input  logic [31:0]           tcfg_rd,
    input  logic [31:0]           tval_rd,
    input  logic                  trap_commit,
    input  logic                  trap_is_ertn,
    input  logic [ECODE_W-1:0]    trap_ecode,
    input  logic [31:0]           trap_epc,
    output logic [31:0]           rdata,
    output logic                  int_req,
    output logic [31:0]           eentry,
    output logic [31:0]           era
);

    // Bits 10 and 12 of the interrupt field are not implemented
    localparam logic [IS_W-1:0] IS_MASK = 13'h0bff;

    logic [1:0]         crmd_plv;
    logic               crmd_ie;
    logic [1:0]         prmd_pplv;
    logic               prmd_pie;
    logic [IS_W-1:0]    ecfg_lie;
    logic [1:0]         swi_q;
    logic [7:0]         hwi_q;
    logic               ti_q;
    logic [ECODE_W-1:0] ecode_q;
    logic [31:0]        era_q;
    logic [31:6]        eentry_q;
    logic [31:0]        save_q [4];
    logic [31:0]        tid_q;
    logic [IS_W-1:0]    estat_is;
    logic               csr_wr;
    logic               ticlr;

    assign csr_wr   = we && !trap_commit;    // Trap commit wins over an instruction write
    assign ticlr    = csr_wr && (addr == CSR_TICLR) && wdata[0];
    assign estat_is = {1'b0, ti_q, 1'b0, hwi_q, swi_q};

    // Mode, enable and status fields, updated by instructions and traps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd_plv  <= 2'b00;
            crmd_ie   <= 1'b0;
            prmd_pplv <= 2'b00;
            prmd_pie  <= 1'b0;
            ecfg_lie  <= '0;
            swi_q     <= 2'b00;
            ecode_q   <= '0;
        end else if (trap_commit) begin
            if (trap_is_ertn) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end else begin
                prmd_pplv <= crmd_plv;
                prmd_pie  <= crmd_ie;
                crmd_plv  <= 2'b00; // Handler runs at kernel level with interrupts off
                crmd_ie   <= 1'b0;
                ecode_q   <= trap_ecode;
            end
        end else if (csr_wr) begin
            case (addr)
                CSR_CRMD:  {crmd_ie, crmd_plv} <= wdata[2:0];
                CSR_PRMD:  {prmd_pie, prmd_pplv} <= wdata[2:0];
                CSR_ECFG:  ecfg_lie <= wdata[IS_W-1:0] & IS_MASK;
                CSR_ESTAT: swi_q <= wdata[1:0]; // Only the software bits are writable
                default:   ;
            endcase
        end
    end

    // Hardware lines are level sensitive and simply sampled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hwi_q <= 8'h00;
            ti_q  <= 1'b0;
        end else begin
            hwi_q <= hwi;
            if (timer_fire) begin
                ti_q <= 1'b1;
            end else if (ticlr) begin
                ti_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trap_commit && !trap_is_ertn) begin
            era_q <= trap_epc;
        end else if (csr_wr) begin
            case (addr)
                CSR_ERA:    era_q <= wdata;
                CSR_EENTRY: eentry_q <= wdata[31:6];
                CSR_SAVE0:  save_q[0] <= wdata;
                CSR_SAVE1:  save_q[1] <= wdata;
                CSR_SAVE2:  save_q[2] <= wdata;
                CSR_SAVE3:  save_q[3] <= wdata;
                CSR_TID:    tid_q <= wdata;
                default:    ;
            endcase
        end
    end

    always_comb begin
        case (addr)
            CSR_CRMD:   rdata = {29'b0, crmd_ie, crmd_plv};
            CSR_PRMD:   rdata = {29'b0, prmd_pie, prmd_pplv};
            CSR_ECFG:   rdata = {19'b0, ecfg_lie};
            CSR_ESTAT:  rdata = {10'b0, ecode_q, 3'b0, estat_is};
            CSR_ERA:    rdata = era_q;
            CSR_EENTRY: rdata = {eentry_q, 6'b0};
            CSR_SAVE0:  rdata = save_q[0];
            CSR_SAVE1:  rdata = save_q[1];
            CSR_SAVE2:  rdata = save_q[2];
            CSR_SAVE3:  rdata = save_q[3];
            CSR_TID:    rdata = tid_q;
            CSR_TCFG:   rdata = tcfg_rd;
            CSR_TVAL:   rdata = tval_rd;
            default:    rdata = 32'b0; // TICLR and unimplemented addresses
        endcase
    end

    assign int_req = crmd_ie && |(estat_is & ecfg_lie);
    assign eentry  = {eentry_q, 6'b0};
    assign era     = era_q;

endmodule

/* csr_timer.sv */
`timescale 1ns/1ps

module csr_timer import csr_pkg::*; #(
    parameter int TIMER_BITS = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [CSR_ADDR_W-1:0] addr,
    input  logic                  we,
    input  logic [31:0]           wdata,
    output logic [31:0]           tcfg_rd,
    output logic [31:0]           tval_rd,
    output logic                  timer_fire
);

    logic [TIMER_BITS-1:0] tcfg_q; // Bit 0 enable, bit 1 periodic, rest initial value
    logic [TIMER_BITS-1:0] cnt_q;
    logic                  running;
    logic                  cfg_we;
    logic [TIMER_BITS-1:0] reload;

    assign cfg_we = we && (addr == CSR_TCFG);
    assign reload = {tcfg_q[TIMER_BITS-1:2], 2'b00}; // Initial value times four

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tcfg_q  <= '0;
            cnt_q   <= '1;
            running <= 1'b0;
        end else if (cfg_we) begin
            tcfg_q  <= wdata[TIMER_BITS-1:0];
            cnt_q   <= {wdata[TIMER_BITS-1:2], 2'b00};
            running <= wdata[0];
        end else if (running) begin
            if (cnt_q == '0) begin
                // A one-shot timer parks at all ones until reconfigured
                running <= tcfg_q[1];
                cnt_q   <= tcfg_q[1] ? reload : '1;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    assign timer_fire = running && (cnt_q == '0);
    assign tcfg_rd    = 32'(tcfg_q);
    assign tval_rd    = 32'(cnt_q);

endmodule

/* csr_top.sv */
`timescale 1ns/1ps

module csr_top import csr_pkg::*; #(
    parameter int TIMER_BITS = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [CSR_ADDR_W-1:0] csr_addr,
    input  logic                  csr_we,
    input  logic [31:0]           csr_wdata,
    output logic [31:0]           csr_rdata,
    input  logic [7:0]            hwi,
    input  logic                  excp_valid,
    input  logic [ECODE_W-1:0]    excp_ecode,
    input  logic [31:0]           excp_epc,
    input  logic                  ertn,
    output logic                  int_req,
    output logic                  busy,
    output logic                  redirect_valid,
    output logic [31:0]           redirect_pc
);

    logic [31:0]        tcfg_rd;
    logic [31:0]        tval_rd;
    logic               timer_fire;
    logic [31:0]        eentry;
    logic [31:0]        era;
    logic               trap_commit;
    logic               trap_is_ertn;
    logic [ECODE_W-1:0] trap_ecode;
    logic [31:0]        trap_epc;

    csr_timer #(
        .TIMER_BITS (TIMER_BITS)
    ) i_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (csr_addr),
        .we         (csr_we),
        .wdata      (csr_wdata),
        .tcfg_rd    (tcfg_rd),
        .tval_rd    (tval_rd),
        .timer_fire (timer_fire)
    );

    csr_regfile i_regfile (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr         (csr_addr),
        .we           (csr_we),
        .wdata        (csr_wdata),
        .hwi          (hwi),
        .timer_fire   (timer_fire),
        .tcfg_rd      (tcfg_rd),
        .tval_rd      (tval_rd),
        .trap_commit  (trap_commit),
        .trap_is_ertn (trap_is_ertn),
        .trap_ecode   (trap_ecode),
        .trap_epc     (trap_epc),
        .rdata        (csr_rdata),
        .int_req      (int_req),
        .eentry       (eentry),
        .era          (era)
    );

    csr_trap_ctrl i_trap_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .excp_valid     (excp_valid),
        .excp_ecode     (excp_ecode),
        .excp_epc       (excp_epc),
        .ertn           (ertn),
        .eentry         (eentry),
        .era            (era),
        .trap_commit    (trap_commit),
        .trap_is_ertn   (trap_is_ertn),
        .trap_ecode     (trap_ecode),
        .trap_epc       (trap_epc),
        .busy           (busy),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* csr_trap_ctrl.sv */
`timescale 1ns/1ps

module csr_trap_ctrl import csr_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               excp_valid,
    input  logic [ECODE_W-1:0] excp_ecode,
    input  logic [31:0]        excp_epc,
    input  logic               ertn,
    input  logic [31:0]        eentry,
    input  logic [31:0]        era,
    output logic               trap_commit,
    output logic               trap_is_ertn,
    output logic [ECODE_W-1:0] trap_ecode,
    output logic [31:0]        trap_epc,
    output logic               busy,
    output logic               redirect_valid,
    output logic [31:0]        redirect_pc
);

    trap_state_t        state_q;
    trap_state_t        state_d;
    logic               accept;
    logic               is_ertn_q;
    logic [ECODE_W-1:0] ecode_q;
    logic [31:0]        epc_q;

    assign accept = (state_q == TRAP_IDLE) && (excp_valid || ertn);

    always_comb begin
        state_d = state_q;
        case (state_q)
            TRAP_IDLE:     if (accept) state_d = TRAP_COMMIT;
            TRAP_COMMIT:   state_d = TRAP_REDIRECT;
            TRAP_REDIRECT: state_d = TRAP_IDLE;
            default:       state_d = TRAP_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= TRAP_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            is_ertn_q <= !excp_valid; // An exception beats a simultaneous return
            ecode_q   <= excp_ecode;
            epc_q     <= excp_epc;
        end
    end

    assign trap_commit    = (state_q == TRAP_COMMIT);
    assign trap_is_ertn   = is_ertn_q;
    assign trap_ecode     = ecode_q;
    assign trap_epc       = epc_q;
    assign busy           = (state_q != TRAP_IDLE);
    assign redirect_valid = (state_q == TRAP_REDIRECT);

    // Register file was updated at the end of the commit cycle
    assign redirect_pc = is_ertn_q ? era : eentry;

endmodule

/* list.f */
csr_pkg.sv
csr_timer.sv
csr_regfile.sv
csr_trap_ctrl.sv
csr_top.sv
csr_properties.sv
tb_csr_top.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the CSR testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_csr_top \
        -f list.f --Mdir obj_dir -o sim_csr; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_csr > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tb_csr_top.sv */
`timescale 1ns/1ps

module tb_csr_top import csr_pkg::*; ();

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic                  csr_we;
    logic [31:0]           csr_wdata;
    logic [31:0]           csr_rdata;
    logic [7:0]            hwi;
    logic                  excp_valid;
    logic [ECODE_W-1:0]    excp_ecode;
    logic [31:0]           excp_epc;
    logic                  ertn;
    logic                  int_req;
    logic                  busy;
    logic                  redirect_valid;
    logic [31:0]           redirect_pc;
    logic [31:0]           lfsr_q = 32'd67;
    int                    errors = 0;
    int                    tests = 0;

    always #4 clk = ~clk;

    csr_top #(.TIMER_BITS(32)) i_dut (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q); // One step for every bit taken
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    // Readback expected from the writable fields of each register
    function automatic logic [31:0] masked_value(input logic [CSR_ADDR_W-1:0] a,
                                                 input logic [31:0] d);
        case (a)
            CSR_CRMD, CSR_PRMD: return d & 32'h0000_0007;
            CSR_ECFG:           return d & 32'h0000_0bff; // Bits 10 and 12 are not there
            CSR_ESTAT:          return d & 32'h0000_0003;
            CSR_EENTRY:         return d & 32'hffff_ffc0;
            default:            return d;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic write_csr(input logic [CSR_ADDR_W-1:0] a, input logic [31:0] d);
        @(posedge clk);
        csr_addr  <= a;
        csr_wdata <= d;
        csr_we    <= 1'b1;
        @(posedge clk);
        csr_we <= 1'b0;
    endtask

    task automatic read_csr(input logic [CSR_ADDR_W-1:0] a, output logic [31:0] d);
        @(posedge clk);
        csr_addr <= a;
        @(negedge clk);
        d = csr_rdata; // Read data settles well before the falling edge
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        if (errors == start)
            $display("Test %s finished without errors", name);
        else
            $display("Test %s finished with %0d errors", name, errors - start);
    endtask

    task automatic wait_timer_pending(output logic seen);
        int n;
        n = 0;
        @(posedge clk);
        csr_addr <= CSR_ESTAT;
        @(negedge clk);
        while (!csr_rdata[11] && n < 200) begin
            @(negedge clk);
            n++;
        end
        seen = csr_rdata[11];
        if (!seen) begin
            $display("Timeout: the timer pending bit in ESTAT was never set");
            errors++;
        end
    endtask

    // Plays the pipeline for one trap and checks the fixed two-cycle redirect
    task automatic run_trap(input logic is_ertn, input logic [ECODE_W-1:0] code,
                            input logic [31:0] pc, input logic [31:0] exp_pc);
        @(posedge clk);
        excp_valid <= !is_ertn;
        ertn       <= is_ertn;
        excp_ecode <= code;
        excp_epc   <= pc;
        @(posedge clk);
        excp_valid <= is_ertn; // The other kind of request is held through both busy cycles
        ertn       <= !is_ertn;
        excp_ecode <= ~code;
        excp_epc   <= ~pc;
        @(negedge clk);
        check_value(32'(busy), 32'd1, "busy in commit cycle");
        check_value(32'(redirect_valid), 32'd0, "redirect_valid in commit cycle");
        @(negedge clk);
        check_value(32'(busy), 32'd1, "busy in redirect cycle");
        check_value(32'(redirect_valid), 32'd1, "redirect_valid in redirect cycle");
        check_value(redirect_pc, exp_pc, "redirect_pc");
        @(posedge clk);
        excp_valid <= 1'b0;
        ertn       <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_value(32'(busy), 32'd0, "busy after redirect"); // Request seen while busy was dropped
            check_value(32'(redirect_valid), 32'd0, "redirect_valid after redirect");
        end
    endtask

    task automatic register_access();
        logic [CSR_ADDR_W-1:0] regs [11] = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT,
            CSR_ERA, CSR_EENTRY, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID};
        logic [31:0] d;
        logic [31:0] r;
        int          start;
        start = errors;
        read_csr(CSR_CRMD, r);
        check_value(r, 32'd0, "CRMD after reset");
        read_csr(CSR_ECFG, r);
        check_value(r, 32'd0, "ECFG after reset");
        foreach (regs[i]) begin
            rand_bits(32, d);
            write_csr(regs[i], d);
            read_csr(regs[i], r);
            check_value(r, masked_value(regs[i], d), $sformatf("CSR %h", regs[i]));
        end
        rand_bits(32, d);
        d[0] = 1'b0; // Counter is loaded but does not run
        write_csr(CSR_TCFG, d);
        read_csr(CSR_TCFG, r);
        check_value(r, d, "TCFG");
        write_csr(CSR_TVAL, ~d);
        read_csr(CSR_TVAL, r);
        check_value(r, d & 32'hffff_fffc, "TVAL after write");
        read_csr(14'h002, r);
        check_value(r, 32'd0, "unimplemented CSR 002");
        read_csr(14'h3ff, r);
        check_value(r, 32'd0, "unimplemented CSR 3ff");
        read_csr(CSR_TICLR, r);
        check_value(r, 32'd0, "TICLR");
        write_csr(CSR_CRMD, 32'd0);
        write_csr(CSR_ECFG, 32'd0);
        write_csr(CSR_ESTAT, 32'd0);
        write_csr(CSR_TCFG, 32'd0);
        report_test("register access", start);
    endtask

    task automatic interrupt_routing();
        logic [31:0] d;
        logic [31:0] r;
        int          start;
        start = errors;
        write_csr(CSR_CRMD, 32'h4);
        write_csr(CSR_ESTAT, 32'h1);
        read_csr(CSR_ESTAT, r);
        check_value(r & 32'h1fff, 32'h1, "ESTAT.is after software write");
        check_value(32'(int_req), 32'd0, "int_req with empty mask");
        write_csr(CSR_ECFG, 32'h1);
        @(negedge clk);
        check_value(32'(int_req), 32'd1, "int_req with software bit enabled");
        write_csr(CSR_CRMD, 32'd0);
        @(negedge clk);
        check_value(32'(int_req), 32'd0, "int_req with CRMD.ie clear");
        write_csr(CSR_CRMD, 32'h4);
        @(negedge clk);
        check_value(32'(int_req), 32'd1, "int_req with CRMD.ie set again");
        write_csr(CSR_ESTAT, 32'd0);
        @(negedge clk);
        check_value(32'(int_req), 32'd0, "int_req with software bit cleared");
        rand_bits(8, d);
        d[0] = 1'b1;
        @(posedge clk);
        hwi <= d[7:0];
        read_csr(CSR_ESTAT, r);
        check_value(r & 32'h1fff, 32'({d[7:0], 2'b00}), "ESTAT.is hardware lines");
        check_value(32'(int_req), 32'd0, "int_req with hardware lines masked");
        write_csr(CSR_ECFG, 32'({d[7:0], 2'b00}));
        @(negedge clk);
        check_value(32'(int_req), 32'd1, "int_req with hardware lines enabled");
        @(posedge clk);
        hwi <= 8'h00;
        @(posedge clk);
        @(negedge clk);
        check_value(32'(int_req), 32'd0, "int_req after hardware lines drop");
        write_csr(CSR_ECFG, 32'd0);
        write_csr(CSR_CRMD, 32'd0);
        report_test("interrupt routing", start);
    endtask

    task automatic one_shot_timer();
        logic [31:0] r;
        logic        seen;
        int          start;
        start = errors;
        write_csr(CSR_TCFG, (32'd3 << 2) | 32'h1);
        wait_timer_pending(seen);
        read_csr(CSR_TVAL, r);
        check_value(r, 32'hffff_ffff, "TVAL after one-shot fire");
        repeat (20) @(posedge clk);
        read_csr(CSR_TVAL, r);
        check_value(r, 32'hffff_ffff, "TVAL some cycles later");
        write_csr(CSR_TICLR, 32'h1);
        read_csr(CSR_ESTAT, r);
        check_value(r & 32'h800, 32'd0, "timer pending after TICLR");
        repeat (30) @(posedge clk);
        read_csr(CSR_ESTAT, r);
        check_value(r & 32'h800, 32'd0, "timer pending stays clear");
        report_test("one-shot timer", start);
    endtask

    task automatic periodic_timer();
        logic [31:0] r;
        logic        seen;
        int          fires;
        int          start;
        start = errors;
        fires = 0;
        write_csr(CSR_TCFG, (32'd4 << 2) | 32'h3);
        repeat (3) begin
            wait_timer_pending(seen);
            if (seen)
                fires++;
            write_csr(CSR_TICLR, 32'h1);
            read_csr(CSR_ESTAT, r);
            check_value(r & 32'h800, 32'd0, "timer pending after TICLR");
        end
        check_value(32'(fires), 32'd3, "periodic fire count");
        @(posedge clk);
        csr_addr <= CSR_TVAL;
        repeat (40) begin
            @(negedge clk);
            if (csr_rdata > 32'd16) begin
                $display("** Error at %0t ns: TVAL %h exceeds reload 10", $time, csr_rdata);
                errors++;
            end
        end
        write_csr(CSR_TCFG, 32'd0);
        write_csr(CSR_TICLR, 32'h1);
        report_test("periodic timer", start);
    endtask

    task automatic exception_entry();
        logic [31:0] base;
        logic [31:0] code;
        logic [31:0] pc;
        logic [31:0] r;
        int          start;
        start = errors;
        rand_bits(32, base);
        write_csr(CSR_EENTRY, base);
        write_csr(CSR_PRMD, 32'd0);
        write_csr(CSR_CRMD, 32'h7); // Interrupts on at user level
        rand_bits(ECODE_W, code);
        rand_bits(32, pc);
        run_trap(1'b0, code[ECODE_W-1:0], pc, base & 32'hffff_ffc0);
        read_csr(CSR_PRMD, r);
        check_value(r, 32'h7, "PRMD after exception");
        read_csr(CSR_CRMD, r);
        check_value(r, 32'd0, "CRMD after exception");
        read_csr(CSR_ERA, r);
        check_value(r, pc, "ERA after exception");
        read_csr(CSR_ESTAT, r);
        check_value((r >> 16) & 32'h3f, code, "ESTAT.Ecode after exception");
        report_test("exception entry", start);
    endtask

    task automatic exception_return();
        logic [31:0] pr;
        logic [31:0] ra;
        logic [31:0] r;
        int          start;
        start = errors;
        rand_bits(3, pr);
        write_csr(CSR_PRMD, pr);
        rand_bits(32, ra);
        write_csr(CSR_ERA, ra);
        run_trap(1'b1, '0, 32'd0, ra);
        read_csr(CSR_CRMD, r);
        check_value(r, pr, "CRMD after return");
        report_test("exception return", start);
    endtask

    initial begin
        rst_n      = 1'b0;
        csr_addr   = '0;
        csr_we     = 1'b0;
        csr_wdata  = '0;
        hwi        = '0;
        excp_valid = 1'b0;
        excp_ecode = '0;
        excp_epc   = '0;
        ertn       = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        register_access();
        interrupt_routing();
        one_shot_timer();
        periodic_timer();
        exception_entry();
        exception_return();
        errors += i_dut.i_trap_ctrl.i_trap_props.fails; // Assertion failures count too
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
